// ==== addr_gen.sv ====
`default_nettype none

module addr_gen (
   input  wire                                  clk,
   input  wire                                  rst,
   input  wire                                  init,
   input  wire                                  run,
   input  wire                                  pause,
   input  wire        [vmem_pkg::addr_w-1:0]    iterations,
   input  wire        [vmem_pkg::period_w-1:0]  period,
   input  wire        [vmem_pkg::period_w-1:0]  duty,
   input  wire        [vmem_pkg::period_w-1:0]  delay,
   input  wire        [vmem_pkg::addr_w-1:0]    start,
   input  wire signed [vmem_pkg::addr_w-1:0]    shift,
   input  wire signed [vmem_pkg::addr_w-1:0]    incr,
   output logic       [vmem_pkg::addr_w-1:0]    addr,
   output logic                                 mem_en,
   output logic                                 done
);
   import vmem_pkg::*;

   typedef enum logic {s_idle, s_run} state_t;

   localparam logic signed [period_w:0] per_one = 1;

   state_t state, state_nxt;

   logic signed [period_w:0] per_cnt, per_cnt_nxt;   // negative while counting delay
   logic signed [period_w:0] period_s, duty_s, delay_s;
   logic [addr_w-1:0]        iter, iter_nxt;
   logic [addr_w-1:0]        addr_nxt;
   logic                     mem_en_nxt;
   logic                     done_nxt;
   logic                     run_pend, pend_nxt;     // run seen during a pass
   logic                     go;
   logic                     last;
   logic                     hold;

   assign period_s = {1'b0, period};
   assign duty_s   = {1'b0, duty};
   assign delay_s  = {1'b0, delay};

   assign go   = run | run_pend;
   assign last = (iter == iterations) && (per_cnt == period_s);
   assign hold = pause && (state == s_run);

   always_comb begin
      state_nxt   = state;
      done_nxt    = done;
      mem_en_nxt  = mem_en;
      per_cnt_nxt = per_cnt;
      addr_nxt    = addr;
      iter_nxt    = iter;
      pend_nxt    = run_pend;

      if (state == s_idle) begin
         done_nxt = 1'b1;
         if (init) begin
            per_cnt_nxt = per_one - delay_s;
            addr_nxt    = start;
            iter_nxt    = 1'b1;
         end
         if (run) begin
            state_nxt  = s_run;
            done_nxt   = 1'b0;
            mem_en_nxt = (delay == '0);
         end
      end else begin
         if (run)
            pend_nxt = 1'b1;

         // enable at delay end or start of a new group
         if (per_cnt == '0 || (per_cnt == period_s && iter != iterations))
            mem_en_nxt = 1'b1;
         if (per_cnt == duty_s && (period != duty || iter == iterations))
            mem_en_nxt = 1'b0;

         if (per_cnt == period_s) begin
            per_cnt_nxt = per_one;
            iter_nxt    = iter + 1'b1;
            addr_nxt    = addr + incr + shift;   // jump to next group
         end else begin
            per_cnt_nxt = per_cnt + per_one;
            if (mem_en && !(per_cnt == duty_s && period != duty))
               addr_nxt = addr + incr;
         end

         // end of pass, only when the final cycle actually advances
         if (last && !pause) begin
            if (go) begin
               addr_nxt   = start;
               iter_nxt   = 1'b1;
               mem_en_nxt = 1'b1;
               pend_nxt   = 1'b0;
            end else begin
               state_nxt  = s_idle;
               mem_en_nxt = 1'b0;
               done_nxt   = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= s_idle;
         mem_en   <= 1'b0;
         done     <= 1'b1;
         addr     <= '0;
         per_cnt  <= '0;
         iter     <= '0;
         run_pend <= 1'b0;
      end else begin
         done     <= done_nxt;
         run_pend <= pend_nxt;
         if (!hold) begin
            state   <= state_nxt;
            mem_en  <= mem_en_nxt;
            addr    <= addr_nxt;
            per_cnt <= per_cnt_nxt;
            iter    <= iter_nxt;
         end
      end
   end

endmodule

`default_nettype wire

// ==== cfg_regs.sv ====
`default_nettype none

module cfg_regs (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                cfg_we,
   input  vmem_pkg::cfg_field_t               cfg_sel,
   input  wire  [vmem_pkg::addr_w-1:0]        cfg_wdata,
   output logic [vmem_pkg::addr_w-1:0]        iterations,
   output logic [vmem_pkg::addr_w-1:0]        start,
   output logic [vmem_pkg::addr_w-1:0]        shift,
   output logic [vmem_pkg::addr_w-1:0]        incr,
   output logic [vmem_pkg::period_w-1:0]      period,
   output logic [vmem_pkg::period_w-1:0]      duty,
   output logic [vmem_pkg::period_w-1:0]      delay,
   output logic                               init,
   output logic                               run
);
   import vmem_pkg::*;

   logic cmd_we;

   assign cmd_we = cfg_we && (cfg_sel == fld_cmd);

   // pattern registers
   always_ff @(posedge clk) begin
      if (rst) begin
         iterations <= '0;
         start      <= '0;
         shift      <= '0;
         incr       <= '0;
         period     <= '0;
         duty       <= '0;
         delay      <= '0;
      end else if (cfg_we) begin
         case (cfg_sel)
            fld_iterations: iterations <= cfg_wdata;
            fld_period:     period     <= cfg_wdata[period_w-1:0];
            fld_duty:       duty       <= cfg_wdata[period_w-1:0];
            fld_delay:      delay      <= cfg_wdata[period_w-1:0];
            fld_start:      start      <= cfg_wdata;
            fld_shift:      shift      <= cfg_wdata;
            fld_incr:       incr       <= cfg_wdata;
            default: ;                           // fld_cmd handled below
         endcase
      end
   end

   // command pulses, high for one cycle after the write
   always_ff @(posedge clk) begin
      if (rst) begin
         init <= 1'b0;
         run  <= 1'b0;
      end else begin
         init <= cmd_we && cfg_wdata[cmd_init_bit];
         run  <= cmd_we && cfg_wdata[cmd_run_bit];
      end
   end

endmodule

`default_nettype wire

// ==== credit_ctrl.sv ====
`default_nettype none

module credit_ctrl (
   input  wire   clk,
   input  wire   rst,
   input  wire   mem_en,
   input  wire   credit_ret,
   output logic  pause,
   output logic  re,
   output logic  out_valid
);
   import vmem_pkg::*;

   logic [credit_w-1:0] credit_cnt;

   // stall the generator once every credit is spent
   assign pause = (credit_cnt == '0);
   assign re    = mem_en && !pause;

   always_ff @(posedge clk) begin
      if (rst) begin
         credit_cnt <= credit_w'(credit_max);
      end else begin
         case ({credit_ret, re})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;   // none, or return and issue together
         endcase
      end
   end

   // data comes back one cycle after the issue
   always_ff @(posedge clk) begin
      if (rst)
         out_valid <= 1'b0;
      else
         out_valid <= re;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
vmem_pkg.sv
cfg_regs.sv
addr_gen.sv
stream_ram.sv
credit_ctrl.sv
stream_mem_unit.sv
stream_mem_unit_properties.sv
tb_stream_mem_unit.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f flist.f \
   --top-module tb_stream_mem_unit \
   -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit 1
fi

exit 0

// ==== stream_mem_unit.sv ====
`default_nettype none

module stream_mem_unit (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               cfg_we,
   input  vmem_pkg::cfg_field_t              cfg_sel,
   input  wire  [vmem_pkg::addr_w-1:0]       cfg_wdata,
   input  wire                               mem_we,
   input  wire  [vmem_pkg::addr_w-1:0]       mem_waddr,
   input  wire  [vmem_pkg::data_w-1:0]       mem_wdata,
   input  wire                               credit_ret,
   output logic [vmem_pkg::data_w-1:0]       out_data,
   output logic                              out_valid,
   output logic                              done
);
   import vmem_pkg::*;

   logic [addr_w-1:0]   iterations, start, shift, incr;
   logic [period_w-1:0] period, duty, delay;
   logic                init, run;
   logic [addr_w-1:0]   addr;
   logic                mem_en;
   logic                pause;
   logic                re;

   cfg_regs u_cfg (
      .clk        (clk),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_sel    (cfg_sel),
      .cfg_wdata  (cfg_wdata),
      .iterations (iterations),
      .start      (start),
      .shift      (shift),
      .incr       (incr),
      .period     (period),
      .duty       (duty),
      .delay      (delay),
      .init       (init),
      .run        (run)
   );

   addr_gen u_agen (
      .clk        (clk),
      .rst        (rst),
      .init       (init),
      .run        (run),
      .pause      (pause),
      .iterations (iterations),
      .period     (period),
      .duty       (duty),
      .delay      (delay),
      .start      (start),
      .shift      (shift),
      .incr       (incr),
      .addr       (addr),
      .mem_en     (mem_en),
      .done       (done)
   );

   stream_ram u_ram (
      .clk   (clk),
      .we    (mem_we),
      .waddr (mem_waddr),
      .wdata (mem_wdata),
      .re    (re),
      .raddr (addr),
      .rdata (out_data)
   );

   credit_ctrl u_credit (
      .clk        (clk),
      .rst        (rst),
      .mem_en     (mem_en),
      .credit_ret (credit_ret),
      .pause      (pause),
      .re         (re),
      .out_valid  (out_valid)
   );

endmodule

`default_nettype wire

// ==== stream_mem_unit_properties.sv ====
`default_nettype none

module stream_mem_unit_properties (
   input wire clk,
   input wire rst,
   input wire credit_ret,
   input wire re,
   input wire pause,
   input wire out_valid,
   input wire done
);
   timeunit 1ns;
   timeprecision 1ps;

   import vmem_pkg::*;

   int credits;   // mirrors the credit counter from returns and issues

   always @(posedge clk) begin
      if (rst)
         credits <= credit_max;
      else
         credits <= credits + int'(credit_ret) - int'(re);
   end

   no_valid_after_stall: assert property (@(posedge clk) disable iff (rst)
      (credits == 0) |=> !out_valid)
      else $error("out_valid one cycle after the credit count was zero");

   credits_bounded: assert property (@(posedge clk) disable iff (rst)
      credits <= credit_max && (pause == (credits == 0)))
      else $error("credit count out of range or pause disagrees with it");

   done_after_reset: assert property (@(posedge clk) rst |=> done)
      else $error("done not high after reset");

endmodule

bind stream_mem_unit stream_mem_unit_properties u_props (
   .clk        (clk),
   .rst        (rst),
   .credit_ret (credit_ret),
   .re         (re),
   .pause      (pause),
   .out_valid  (out_valid),
   .done       (done)
);

`default_nettype wire

// ==== stream_ram.sv ====
`default_nettype none

module stream_ram (
   input  wire                             clk,
   input  wire                             we,
   input  wire  [vmem_pkg::addr_w-1:0]     waddr,
   input  wire  [vmem_pkg::data_w-1:0]     wdata,
   input  wire                             re,
   input  wire  [vmem_pkg::addr_w-1:0]     raddr,
   output logic [vmem_pkg::data_w-1:0]     rdata
);
   import vmem_pkg::*;

   localparam int depth = 2 ** addr_w;

   logic [data_w-1:0] mem [depth];

   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // read before write on a shared address
   always_ff @(posedge clk) begin
      if (re)
         rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

// ==== tb_stream_mem_unit.sv ====
`default_nettype none

module tb_stream_mem_unit;
   timeunit 1ns;
   timeprecision 1ps;

   import vmem_pkg::*;

   localparam int depth = 2 ** addr_w;

   logic                 clk;
   logic                 rst;
   logic                 cfg_we;
   cfg_field_t           cfg_sel;
   logic [addr_w-1:0]    cfg_wdata;
   logic                 mem_we;
   logic [addr_w-1:0]    mem_waddr;
   logic [data_w-1:0]    mem_wdata;
   logic                 credit_ret;
   logic [data_w-1:0]    out_data;
   logic                 out_valid;
   logic                 done;

   logic [31:0]          lfsr;
   logic [data_w-1:0]    mem_model [depth];   // copy of the preloaded RAM
   logic [data_w-1:0]    rx_q [$];
   int                   cons_mode;           // 0 immediate, 1 withhold, 2 gapped
   int                   gaps [64];
   int                   credits_returned;
   int                   gap_cnt;
   int                   gap_idx;
   int                   p_iter, p_duty, p_start, p_shift, p_incr;

   stream_mem_unit DUT (
      .clk        (clk),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_sel    (cfg_sel),
      .cfg_wdata  (cfg_wdata),
      .mem_we     (mem_we),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata),
      .credit_ret (credit_ret),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .done       (done)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
         v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   // read j of group i, wraps at addr_w bits
   function automatic logic [addr_w-1:0] pattern_addr(input int i, input int j);
      int a;
      a = p_start + i * (p_duty * p_incr + p_shift) + j * p_incr;
      return addr_w'(a);
   endfunction

   always @(negedge clk) begin
      if (out_valid === 1'b1)
         rx_q.push_back(out_data);
   end

   // consumer hands back one credit per accepted word
   initial begin
      credit_ret = 1'b0;
      credits_returned = 0;
      gap_cnt = 0;
      gap_idx = 0;
      forever begin
         @(posedge clk);
         #2;
         credit_ret = 1'b0;
         if (!rst && cons_mode != 1 && rx_q.size() > credits_returned) begin
            if (gap_cnt > 0) begin
               gap_cnt--;
            end else begin
               credit_ret = 1'b1;
               credits_returned++;
               if (cons_mode == 2) begin
                  gap_cnt = gaps[gap_idx];
                  gap_idx = (gap_idx + 1) % 64;
               end
            end
         end
      end
   end

   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      if (actual !== expected) begin
         $display("error at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic cfg_write(input cfg_field_t sel, input logic [addr_w-1:0] data);
      cfg_we    = 1'b1;
      cfg_sel   = sel;
      cfg_wdata = data;
      tick();
      cfg_we    = 1'b0;
   endtask

   task automatic set_pattern(input int iter, input int period, input int duty,
                              input int start, input int shift, input int incr);
      p_iter  = iter;
      p_duty  = duty;
      p_start = start;
      p_shift = shift;
      p_incr  = incr;
      cfg_write(fld_iterations, addr_w'(iter));
      cfg_write(fld_period, addr_w'(period));
      cfg_write(fld_duty, addr_w'(duty));
      cfg_write(fld_delay, '0);
      cfg_write(fld_start, addr_w'(start));
      cfg_write(fld_shift, addr_w'(shift));
      cfg_write(fld_incr, addr_w'(incr));
   endtask

   task automatic start_run();
      cfg_write(fld_cmd, addr_w'((1 << cmd_init_bit) | (1 << cmd_run_bit)));
      tick();                                   // run pulse has been seen
      check(done, 1'b0, "done low after run");
   endtask

   task automatic wait_done(input int limit);
      int n;
      n = 0;
      while (done !== 1'b1 && n < limit) begin
         tick();
         n++;
      end
      if (done !== 1'b1) begin
         $display("timeout: done did not return high within %0d cycles", limit);
         $display("Test failed");
         $fatal(1, "timeout");
      end
      tick();   // last word trails done by a cycle
      tick();
   endtask

   task automatic preload_memory();
      for (int a = 0; a < depth; a++) begin
         mem_model[a] = random_bits(data_w);
         mem_we    = 1'b1;
         mem_waddr = addr_w'(a);
         mem_wdata = mem_model[a];
         tick();
      end
      mem_we = 1'b0;
   endtask

   task automatic compare_stream(input int base, input int passes);
      int n;
      n = base;
      check(rx_q.size(), base + passes * p_iter * p_duty, "stream length");
      for (int p = 0; p < passes; p++)
         for (int i = 0; i < p_iter; i++)
            for (int j = 0; j < p_duty; j++) begin
               check(rx_q[n], mem_model[pattern_addr(i, j)], "stream word");
               n++;
            end
   endtask

   task automatic reset_state();
      check(done, 1'b1, "done after reset");
      for (int k = 0; k < 10; k++) begin
         check(out_valid, 1'b0, "out_valid idle after reset");
         tick();
      end
      check(rx_q.size(), 0, "no words after reset");
   endtask

   task automatic linear_run();
      int base;
      base = rx_q.size();
      set_pattern(1, 8, 8, 'hfc, 0, 1);         // crosses the top of memory
      start_run();
      wait_done(100);
      compare_stream(base, 1);
   endtask

   task automatic two_level_run();
      int base;
      base = rx_q.size();
      set_pattern(3, 6, 3, 'h40, -7, 5);
      start_run();
      wait_done(100);
      compare_stream(base, 1);
   endtask

   task automatic back_pressure_run();
      int base;
      for (int k = 0; k < 64; k++)
         gaps[k] = int'(random_bits(3));
      base = rx_q.size();
      set_pattern(3, 5, 4, 'h80, 3, 2);
      cons_mode = 1;
      start_run();
      repeat (20) tick();
      check(rx_q.size() - base, credit_max, "words while credits withheld");
      check(done, 1'b0, "done low while stalled");
      cons_mode = 2;
      wait_done(400);
      compare_stream(base, 1);
      cons_mode = 0;
   endtask

   task automatic back_to_back_run();
      int base;
      base = rx_q.size();
      set_pattern(2, 4, 2, 'h10, -1, 3);
      start_run();
      tick();
      tick();
      cfg_write(fld_cmd, addr_w'(1 << cmd_run_bit));   // second run mid pass
      repeat (6) tick();
      check(done, 1'b0, "done low between passes");
      wait_done(100);
      compare_stream(base, 2);
   endtask

   initial begin
      rst       = 1'b1;
      cfg_we    = 1'b0;
      cfg_sel   = fld_iterations;
      cfg_wdata = '0;
      mem_we    = 1'b0;
      mem_waddr = '0;
      mem_wdata = '0;
      cons_mode = 0;
      lfsr      = 32'h294d_e2df;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;

      reset_state();
      preload_memory();
      linear_run();
      two_level_run();
      back_pressure_run();
      back_to_back_run();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vmem_pkg.sv ====
`default_nettype none

package vmem_pkg;

   // address, iteration count, start, shift and incr
   localparam int addr_w = 8;

   // period, duty and delay
   localparam int period_w = 5;

   // memory word
   localparam int data_w = 32;

   // credits granted by the consumer out of reset
   localparam int credit_max = 4;
   localparam int credit_w = $clog2(credit_max + 1);

   // select for host configuration writes
   typedef enum logic [2:0] {
      fld_iterations,
      fld_period,
      fld_duty,
      fld_delay,
      fld_start,
      fld_shift,
      fld_incr,
      fld_cmd                // not stored, issues init/run pulses
   } cfg_field_t;

   // bit positions inside a command write
   localparam int cmd_init_bit = 0;
   localparam int cmd_run_bit = 1;

endpackage

`default_nettype wire
